// File: logic/rtc_set_pkg.sv
`default_nettype none

package rtc_set_pkg;

	//////////////////////////////
	// Field geometry
	//////////////////////////////

	// Seconds, minutes and hours
	localparam int num_fields = 3;

	// Binary field width, wide enough for 59
	localparam int field_w = 6;

	// Width of one BCD digit
	localparam int digit_w = 4;

	// Positions of the fields in the value arrays
	localparam int idx_sec  = 0;
	localparam int idx_min  = 1;
	localparam int idx_hour = 2;

	//////////////////////////////
	// Field values and limits
	//////////////////////////////

	// One binary field value
	typedef logic [field_w-1:0] field_value_t;

	// Largest value of each field, indexed as above
	localparam field_value_t field_max [num_fields] = '{
		6'd59,
		6'd59,
		6'd23
	};

	//////////////////////////////
	// Cursor and step commands
	//////////////////////////////

	// Field being set, cur_none freezes all fields
	typedef enum logic [1:0] {
		cur_none = 2'd0,
		cur_sec  = 2'd1,
		cur_min  = 2'd2,
		cur_hour = 2'd3
	} cursor_e;

	// Step strobe for one field, at most one member set
	typedef struct packed {
		logic up;
		logic down;
	} field_step_t;

	// Idle command
	localparam field_step_t step_none = '{up: 1'b0, down: 1'b0};

	//////////////////////////////
	// Display digits
	//////////////////////////////

	typedef logic [digit_w-1:0] bcd_digit_t;

	// Hours in the upper bits, seconds in the lower
	typedef struct packed {
		bcd_digit_t hour_tens;
		bcd_digit_t hour_ones;
		bcd_digit_t min_tens;
		bcd_digit_t min_ones;
		bcd_digit_t sec_tens;
		bcd_digit_t sec_ones;
	} time_bcd_t;

endpackage

`default_nettype wire

// File: logic/step_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module step_decoder (
	input  logic                     btn_pulse,
	input  logic                     reset,
	input  rtc_set_pkg::cursor_e     cursor,
	input  logic                     up,
	input  logic                     down,
	output rtc_set_pkg::field_step_t steps [rtc_set_pkg::num_fields]
);

	import rtc_set_pkg::*;

	// One-hot select of the field under the cursor
	logic [num_fields-1:0] field_sel;

	// Command from the buttons, before field selection
	field_step_t press;

	// Command each field gets on the next edge
	field_step_t steps_next [num_fields];

	//////////////////////////////
	// Cursor decode
	//////////////////////////////

	always_comb begin
		field_sel = '0;
		case (cursor)
			cur_sec: begin
				field_sel[idx_sec] = 1'b1;
			end
			cur_min: begin
				field_sel[idx_min] = 1'b1;
			end
			cur_hour: begin
				field_sel[idx_hour] = 1'b1;
			end
			cur_none: begin
				field_sel = '0;
			end
			default: begin
				field_sel = '0;
			end
		endcase
	end

	//////////////////////////////
	// Button priority
	//////////////////////////////

	// Up wins when both buttons are held
	always_comb begin
		press = step_none;
		if (up) begin
			press.up = 1'b1;
		end else if (down) begin
			press.down = 1'b1;
		end
	end

	// Only the selected field sees the press
	always_comb begin
		for (int i = 0; i < num_fields; i++) begin
			if (field_sel[i]) begin
				steps_next[i] = press;
			end else begin
				steps_next[i] = step_none;
			end
		end
	end

	//////////////////////////////
	// Command register
	//////////////////////////////

	// One-cycle strobes, applied by the counters on the following edge
	always_ff @(posedge btn_pulse or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < num_fields; i++) begin
				steps[i] <= step_none;
			end
		end else begin
			for (int i = 0; i < num_fields; i++) begin
				steps[i] <= steps_next[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/field_counter.sv
`timescale 1ns/1ps
`default_nettype none

module field_counter #(
	parameter rtc_set_pkg::field_value_t field_limit = 6'd59
) (
	input  logic                      btn_pulse,
	input  logic                      reset,
	input  rtc_set_pkg::field_step_t  step,
	output rtc_set_pkg::field_value_t value
);

	import rtc_set_pkg::*;

	// Wrap points in each direction
	logic at_limit;
	logic at_zero;

	// Neighbours of the current value
	field_value_t value_inc;
	field_value_t value_dec;

	// Value after this edge
	field_value_t value_next;

	//////////////////////////////
	// Wrap detection
	//////////////////////////////

	assign at_limit = (value == field_limit);
	assign at_zero  = (value == '0);

	//////////////////////////////
	// Step arithmetic
	//////////////////////////////

	// Up from the limit goes back to zero
	always_comb begin
		if (at_limit) begin
			value_inc = '0;
		end else begin
			value_inc = value + 1'b1;
		end
	end

	// Down from zero goes round to the limit
	always_comb begin
		if (at_zero) begin
			value_dec = field_limit;
		end else begin
			value_dec = value - 1'b1;
		end
	end

	// Hold unless a strobe arrives
	always_comb begin
		value_next = value;
		if (step.up) begin
			value_next = value_inc;
		end else if (step.down) begin
			value_next = value_dec;
		end
	end

	//////////////////////////////
	// Field register
	//////////////////////////////

	// No carry into the next field while setting
	always_ff @(posedge btn_pulse or posedge reset) begin
		if (reset) begin
			value <= '0;
		end else begin
			value <= value_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/bcd_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_formatter (
	input  rtc_set_pkg::field_value_t values [rtc_set_pkg::num_fields],
	output rtc_set_pkg::time_bcd_t    digits
);

	import rtc_set_pkg::*;

	// Split digits of each field
	bcd_digit_t tens [num_fields];
	bcd_digit_t ones [num_fields];

	//////////////////////////////
	// Digit split
	//////////////////////////////

	// Tens digit by comparison against multiples of ten
	function automatic bcd_digit_t tens_of(input field_value_t v);
		bcd_digit_t t;
		if (v >= 6'd50) begin
			t = 4'd5;
		end else if (v >= 6'd40) begin
			t = 4'd4;
		end else if (v >= 6'd30) begin
			t = 4'd3;
		end else if (v >= 6'd20) begin
			t = 4'd2;
		end else if (v >= 6'd10) begin
			t = 4'd1;
		end else begin
			t = 4'd0;
		end
		return t;
	endfunction

	// Remainder once the tens are taken off
	function automatic bcd_digit_t ones_of(input field_value_t v, input bcd_digit_t t);
		field_value_t tens_part;
		field_value_t rem;
		tens_part = field_value_t'(t) * field_value_t'(10);
		rem = v - tens_part;
		return rem[digit_w-1:0];
	endfunction

	always_comb begin
		for (int i = 0; i < num_fields; i++) begin
			tens[i] = tens_of(values[i]);
			ones[i] = ones_of(values[i], tens[i]);
		end
	end

	//////////////////////////////
	// Display packing
	//////////////////////////////

	// Hours first, as the display reads left to right
	always_comb begin
		digits.hour_tens = tens[idx_hour];
		digits.hour_ones = ones[idx_hour];
		digits.min_tens  = tens[idx_min];
		digits.min_ones  = ones[idx_min];
		digits.sec_tens  = tens[idx_sec];
		digits.sec_ones  = ones[idx_sec];
	end

endmodule

`default_nettype wire

// File: logic/rtc_time_set_top.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_time_set_top (
	input  logic                   btn_pulse,
	input  logic                   reset,
	input  rtc_set_pkg::cursor_e   cursor,
	input  logic                   up,
	input  logic                   down,
	output rtc_set_pkg::time_bcd_t digits
);

	import rtc_set_pkg::*;

	// Registered strobes, one per field
	field_step_t steps [num_fields];

	// Binary field values, seconds at index 0
	field_value_t values [num_fields];

	//////////////////////////////
	// Button decode
	//////////////////////////////

	step_decoder i_step_decoder (
		.btn_pulse (btn_pulse),
		.reset     (reset),
		.cursor    (cursor),
		.up        (up),
		.down      (down),
		.steps     (steps)
	);

	//////////////////////////////
	// Field counters
	//////////////////////////////

	// Same counter for every field, only the limit changes
	generate
		for (genvar i = 0; i < num_fields; i++) begin : g_field
			field_counter #(
				.field_limit (field_max[i])
			) i_field_counter (
				.btn_pulse (btn_pulse),
				.reset     (reset),
				.step      (steps[i]),
				.value     (values[i])
			);
		end
	endgenerate

	//////////////////////////////
	// Display digits
	//////////////////////////////

	// Combinational, so digits trail the buttons by two edges
	bcd_formatter i_bcd_formatter (
		.values (values),
		.digits (digits)
	);

endmodule

`default_nettype wire

// File: dv/rtc_ref_model.svh
`ifndef RTC_REF_MODEL_SVH
`define RTC_REF_MODEL_SVH

//////////////////////////////
// Model state
//////////////////////////////

// Step sampled on one edge, still on its way to the counters
typedef struct packed {
	cursor_e cur;
	logic    inc;
	logic    dec;
} pending_t;

// Expected binary fields, seconds at index 0
int exp_field [num_fields];

// Steps in flight, never more than two
pending_t pending_q [$];

//////////////////////////////
// Reference function
//////////////////////////////

// Expected display, tens and ones by divide by ten
function automatic time_bcd_t expected_digits(input int sec, input int min, input int hour);
	time_bcd_t d;
	int t_sec;
	int t_min;
	int t_hour;
	int o_sec;
	int o_min;
	int o_hour;
	t_sec  = sec / 10;
	o_sec  = sec % 10;
	t_min  = min / 10;
	o_min  = min % 10;
	t_hour = hour / 10;
	o_hour = hour % 10;
	d.hour_tens = t_hour[3:0];
	d.hour_ones = o_hour[3:0];
	d.min_tens  = t_min[3:0];
	d.min_ones  = o_min[3:0];
	d.sec_tens  = t_sec[3:0];
	d.sec_ones  = o_sec[3:0];
	return d;
endfunction

//////////////////////////////
// Step rules
//////////////////////////////

// Up has priority over down
function automatic pending_t sample_step(input cursor_e c, input logic u, input logic d);
	pending_t p;
	p.cur = c;
	p.inc = u;
	p.dec = d && !u;
	return p;
endfunction

// Wrap in both directions, no carry into the next field
function automatic void apply_step(input pending_t p);
	int idx;
	int limit;
	idx = -1;
	limit = 0;
	case (p.cur)
		cur_sec: begin
			idx = 0;
			limit = int'(field_max[0]);
		end
		cur_min: begin
			idx = 1;
			limit = int'(field_max[1]);
		end
		cur_hour: begin
			idx = 2;
			limit = int'(field_max[2]);
		end
		default: begin
			idx = -1;
		end
	endcase
	if (idx < 0) begin
		return;
	end
	if (p.inc) begin
		exp_field[idx] = (exp_field[idx] == limit) ? 0 : exp_field[idx] + 1;
	end else if (p.dec) begin
		exp_field[idx] = (exp_field[idx] == 0) ? limit : exp_field[idx] - 1;
	end
endfunction

function automatic void reset_model();
	for (int i = 0; i < num_fields; i++) begin
		exp_field[i] = 0;
	end
	pending_q.delete();
endfunction

// Sampled step lands one edge later, so two edges before it shows
function automatic void advance_model(input cursor_e c, input logic u, input logic d);
	pending_q.push_back(sample_step(c, u, d));
	if (pending_q.size() > 1) begin
		apply_step(pending_q.pop_front());
	end
endfunction

//////////////////////////////
// Compare
//////////////////////////////

task automatic check_equal(input string name, input time_bcd_t got, input time_bcd_t expected);
	if (got !== expected) begin
		error_count++;
		$display("MISMATCH %s: got 0x%06h, expected 0x%06h at %0t",
			name, got, expected, $time);
	end
endtask

`endif

// File: dv/rtc_time_set_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_time_set_tb;

	import rtc_set_pkg::*;

	localparam int clk_period = 100;

	// Edges spent by each test, used for the watchdog
	localparam int reset_cycles     = 8;
	localparam int idle_cycles      = 22;
	localparam int wrap_up_cycles   = 157;
	localparam int wrap_down_cycles = 9;
	localparam int held_cycles      = 15;
	localparam int random_edges     = 400;
	localparam int random_cycles    = random_edges + 2;
	localparam int margin_cycles    = 50;
	localparam int total_cycles     = reset_cycles + idle_cycles + wrap_up_cycles
		+ wrap_down_cycles + held_cycles + random_cycles + margin_cycles;

	logic      btn_pulse;
	logic      reset;
	cursor_e   cursor;
	logic      up;
	logic      down;
	time_bcd_t digits;

	int error_count;
	int test_count;
	int test_start_errors;

	`include "rtc_ref_model.svh"

	rtc_time_set_top i_rtc_time_set_top (
		.btn_pulse (btn_pulse),
		.reset     (reset),
		.cursor    (cursor),
		.up        (up),
		.down      (down),
		.digits    (digits)
	);

	//////////////////////////////
	// Clock, model, compare
	//////////////////////////////

	initial begin
		btn_pulse = 1'b0;
		forever #(clk_period / 2) btn_pulse = ~btn_pulse;
	end

	always @(posedge btn_pulse or posedge reset) begin
		if (reset) begin
			reset_model();
		end else begin
			advance_model(cursor, up, down);
		end
	end

	// Digits settle after the rising edge, check them half a cycle later
	initial begin
		@(posedge btn_pulse);
		forever begin
			@(negedge btn_pulse);
			check_equal("digits", digits,
				expected_digits(exp_field[0], exp_field[1], exp_field[2]));
		end
	end

	initial begin
		#(total_cycles * clk_period);
		$display("Run timed out after %0d cycles without finishing the tests", total_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// Called just after an edge, returns just after the next one
	task automatic apply_inputs(input cursor_e c, input logic u, input logic d);
		cursor = c;
		up = u;
		down = d;
		@(posedge btn_pulse);
		#5;
	endtask

	task automatic step_field(input cursor_e c, input logic u, input logic d, input int count);
		repeat (count) apply_inputs(c, u, d);
	endtask

	// Two idle edges drain the step pipeline
	task automatic flush_pipeline();
		step_field(cur_none, 1'b0, 1'b0, 2);
	endtask

	task automatic start_test();
		test_start_errors = error_count;
		test_count++;
	endtask

	task automatic finish_test(input string name);
		$display("Test %0d %s: %s", test_count, name,
			(error_count == test_start_errors) ? "passed" : "failed");
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic reset_and_idle();
		logic [31:0] rnd;
		start_test();
		check_equal("digits", digits, time_bcd_t'(24'h000000));
		for (int i = 0; i < idle_cycles - 2; i++) begin
			rnd = $urandom;
			apply_inputs(cur_none, rnd[0], rnd[1]);
		end
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h000000));
		finish_test("reset_and_idle");
	endtask

	task automatic wrap_upward();
		start_test();
		// Sampled on this edge, applied on the next
		apply_inputs(cur_sec, 1'b1, 1'b0);
		check_equal("digits", digits, time_bcd_t'(24'h000000));
		apply_inputs(cur_none, 1'b0, 1'b0);
		check_equal("digits", digits, time_bcd_t'(24'h000001));
		step_field(cur_sec, 1'b1, 1'b0, 58);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h000059));
		step_field(cur_sec, 1'b1, 1'b0, 1);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h000000));
		step_field(cur_min, 1'b1, 1'b0, 59);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h005900));
		step_field(cur_min, 1'b1, 1'b0, 1);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h000000));
		step_field(cur_hour, 1'b1, 1'b0, 23);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h230000));
		step_field(cur_hour, 1'b1, 1'b0, 1);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h000000));
		finish_test("wrap_upward");
	endtask

	task automatic wrap_downward();
		start_test();
		step_field(cur_sec, 1'b0, 1'b1, 1);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h000059));
		step_field(cur_min, 1'b0, 1'b1, 1);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h005959));
		step_field(cur_hour, 1'b0, 1'b1, 1);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h235959));
		finish_test("wrap_downward");
	endtask

	// Starts from 23:59:59, unselected fields must keep their digits
	task automatic both_buttons_held();
		start_test();
		step_field(cur_sec, 1'b1, 1'b1, 3);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h235902));
		step_field(cur_min, 1'b1, 1'b1, 3);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h230202));
		step_field(cur_hour, 1'b1, 1'b1, 3);
		flush_pipeline();
		check_equal("digits", digits, time_bcd_t'(24'h020202));
		finish_test("both_buttons_held");
	endtask

	// New cursor and buttons on every edge
	task automatic random_sequences();
		logic [31:0] rnd;
		start_test();
		for (int i = 0; i < random_edges; i++) begin
			rnd = $urandom;
			apply_inputs(cursor_e'(rnd[1:0]), rnd[2], rnd[3]);
		end
		flush_pipeline();
		finish_test("random_sequences");
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		error_count = 0;
		test_count = 0;
		test_start_errors = 0;
		void'($urandom(32'hc40db6e2));
		reset = 1'b1;
		cursor = cur_none;
		up = 1'b0;
		down = 1'b0;
		repeat (reset_cycles) @(posedge btn_pulse);
		#5;
		reset = 1'b0;

		reset_and_idle();
		wrap_upward();
		wrap_downward();
		both_buttons_held();
		random_sequences();

		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtc_time_set.f
+incdir+dv
logic/rtc_set_pkg.sv
logic/step_decoder.sv
logic/field_counter.sv
logic/bcd_formatter.sv
logic/rtc_time_set_top.sv
dv/rtc_time_set_tb.sv
